// ==== Bender.yml ====
package:
  name: vector_lane

sources:
  # Package first, then the lane blocks and the top level
  - lane_pkg.sv
  - lane_decode.sv
  - lane_vrf.sv
  - lane_alu.sv
  - lane_result.sv
  - vector_lane.sv

  # Testbench
  - target: simulation
    files:
      - tb_vector_lane.sv

// ==== lane_alu.sv ====
`timescale 1ns/1ns

module lane_alu (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               issue_valid_i,
  input  lane_pkg::lane_op_e issue_op_i,
  input  lane_pkg::vid_t     issue_id_i,
  input  lane_pkg::vreg_t    issue_vd_i,
  input  lane_pkg::eidx_t    issue_eidx_i,
  input  logic               issue_last_i,
  input  lane_pkg::elem_t    rd_data_a_i,
  input  lane_pkg::elem_t    rd_data_b_i,
  output logic               wb_valid_o,
  output lane_pkg::lane_op_e wb_op_o,
  output lane_pkg::vid_t     wb_id_o,
  output lane_pkg::vaddr_t   wb_addr_o,
  output lane_pkg::elem_t    wb_data_o,
  output logic               wb_last_o
);
  import lane_pkg::*;

  // Stage one in step with the VRF read
  logic     s1_valid_q, s1_last_q;
  lane_op_e s1_op_q;
  vid_t     s1_id_q;
  vreg_t    s1_vd_q;
  eidx_t    s1_eidx_q;
  elem_t    result;

  // Operand order is vs2 op vs1
  always_comb begin
    case (s1_op_q)
      OP_ADD:  result = rd_data_b_i + rd_data_a_i;
      OP_SUB:  result = rd_data_b_i - rd_data_a_i;
      OP_AND:  result = rd_data_b_i & rd_data_a_i;
      OP_OR:   result = rd_data_b_i | rd_data_a_i;
      OP_XOR:  result = rd_data_b_i ^ rd_data_a_i;
      default: result = rd_data_b_i; // store passes vs2 on
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      s1_valid_q <= issue_valid_i;
      wb_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op_q   <= issue_op_i;
    s1_id_q   <= issue_id_i;
    s1_vd_q   <= issue_vd_i;
    s1_eidx_q <= issue_eidx_i;
    s1_last_q <= issue_last_i;
    wb_op_o   <= s1_op_q;
    wb_id_o   <= s1_id_q;
    wb_addr_o <= {s1_vd_q, s1_eidx_q};
    wb_data_o <= result;
    wb_last_o <= s1_last_q;
  end

endmodule

// ==== lane_decode.sv ====
`timescale 1ns/1ns

module lane_decode (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               insn_valid_i,
  input  lane_pkg::lane_op_e insn_op_i,
  input  lane_pkg::vid_t     insn_id_i,
  input  lane_pkg::vlen_t    insn_vl_i,
  input  lane_pkg::vreg_t    insn_vd_i,
  input  lane_pkg::vreg_t    insn_vs1_i,
  input  lane_pkg::vreg_t    insn_vs2_i,
  input  logic               store_credit_i,
  output logic               insn_ready_o,
  output logic               issue_valid_o,
  output lane_pkg::lane_op_e issue_op_o,
  output lane_pkg::vid_t     issue_id_o,
  output lane_pkg::vreg_t    issue_vd_o,
  output lane_pkg::eidx_t    issue_eidx_o,
  output logic               issue_last_o,
  output lane_pkg::vaddr_t   rd_addr_a_o,
  output lane_pkg::vaddr_t   rd_addr_b_o
);
  import lane_pkg::*;

  logic                     busy_q, drain_q;
  logic                     accept, store_op;
  eidx_t                    eidx_q;
  vreg_t                    vs1_q, vs2_q;
  vlen_t                    vl_q;
  logic [StoreCntWidth-1:0] credits_d, credits_q;

  assign insn_ready_o = !busy_q && !drain_q;
  assign accept       = insn_valid_i && insn_ready_o;
  assign store_op     = (issue_op_o == OP_STORE);

  // Stores only go out while a FIFO slot is reserved
  assign issue_valid_o = busy_q && (!store_op || (credits_q != '0));
  assign issue_eidx_o  = eidx_q;
  assign issue_last_o  = (vlen_t'(eidx_q) + vlen_t'(1)) == vl_q;
  assign rd_addr_a_o   = {vs1_q, eidx_q};
  assign rd_addr_b_o   = {vs2_q, eidx_q};

  // One credit taken per store issue, one returned per FIFO pop
  always_comb begin
    credits_d = credits_q;
    if (issue_valid_o && store_op) begin
      credits_d = credits_d - StoreCntWidth'(1);
    end
    if (store_credit_i) begin
      credits_d = credits_d + StoreCntWidth'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      drain_q   <= 1'b0;
      eidx_q    <= '0;
      credits_q <= StoreCntWidth'(StoreDepth);
    end else begin
      credits_q <= credits_d;
      if (accept) begin
        busy_q <= 1'b1;
        eidx_q <= '0;
      end else if (issue_valid_o) begin
        busy_q <= !issue_last_o;
        eidx_q <= eidx_q + eidx_t'(1);
      end
      // Drain until the pipeline is empty and every store slot came back
      if (issue_valid_o && issue_last_o) begin
        drain_q <= 1'b1;
      end else if (credits_q == StoreCntWidth'(StoreDepth)) begin
        drain_q <= 1'b0;
      end
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_op_o <= insn_op_i;
      issue_id_o <= insn_id_i;
      issue_vd_o <= insn_vd_i;
      vs1_q      <= insn_vs1_i;
      vs2_q      <= insn_vs2_i;
      vl_q       <= insn_vl_i;
    end
  end

endmodule

// ==== lane_pkg.sv ====
package lane_pkg;

  ////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////

  // Register file shape
  localparam int unsigned NrVRegs   = 32;
  localparam int unsigned NrElems   = 8;
  localparam int unsigned ElemWidth = 32;

  // Store FIFO entries and the decode credit budget
  localparam int unsigned StoreDepth = 4;

  // Derived widths
  localparam int unsigned VRegWidth     = $clog2(NrVRegs);
  localparam int unsigned EidxWidth     = $clog2(NrElems);
  localparam int unsigned StorePtrWidth = $clog2(StoreDepth);
  localparam int unsigned StoreCntWidth = $clog2(StoreDepth + 1);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [VRegWidth-1:0] vreg_t;
  typedef logic [EidxWidth-1:0] eidx_t;
  // Register number on top and element index below
  typedef logic [VRegWidth+EidxWidth-1:0] vaddr_t;
  // Holds 1 to NrElems
  typedef logic [EidxWidth:0] vlen_t;
  typedef logic [1:0] vid_t;

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_STORE = 3'd5
  } lane_op_e;

endpackage

// ==== lane_result.sv ====
`timescale 1ns/1ns

module lane_result (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               wb_valid_i,
  input  lane_pkg::lane_op_e wb_op_i,
  input  lane_pkg::vid_t     wb_id_i,
  input  lane_pkg::vaddr_t   wb_addr_i,
  input  lane_pkg::elem_t    wb_data_i,
  input  logic               wb_last_i,
  input  logic               ldu_req_i,
  input  lane_pkg::vaddr_t   ldu_addr_i,
  input  lane_pkg::elem_t    ldu_wdata_i,
  input  logic               stu_operand_ready_i,
  output logic               ldu_gnt_o,
  output logic               we_o,
  output lane_pkg::vaddr_t   waddr_o,
  output lane_pkg::elem_t    wdata_o,
  output lane_pkg::elem_t    stu_operand_o,
  output logic               stu_operand_valid_o,
  output logic               store_credit_o,
  output logic               done_o,
  output lane_pkg::vid_t     done_id_o
);
  import lane_pkg::*;

  logic                     alu_we, push, pop;
  logic                     alu_done, store_done;
  logic [StorePtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [StoreCntWidth-1:0] cnt_q;
  elem_t                    fifo_data_q [StoreDepth];
  vid_t                     fifo_id_q   [StoreDepth];
  logic                     fifo_last_q [StoreDepth];

  ////////////////////////////////////////
  // VRF write arbitration
  ////////////////////////////////////////

  // ALU results win, loads fill the free cycles
  assign alu_we    = wb_valid_i && (wb_op_i != OP_STORE);
  assign ldu_gnt_o = ldu_req_i && !alu_we;
  assign we_o      = alu_we || ldu_req_i;
  assign waddr_o   = alu_we ? wb_addr_i : ldu_addr_i;
  assign wdata_o   = alu_we ? wb_data_i : ldu_wdata_i;

  ////////////////////////////////////////
  // Store FIFO
  ////////////////////////////////////////

  assign push                = wb_valid_i && (wb_op_i == OP_STORE);
  assign stu_operand_valid_o = (cnt_q != '0);
  assign stu_operand_o       = fifo_data_q[rd_ptr_q];
  assign pop                 = stu_operand_valid_o && stu_operand_ready_i;
  assign store_credit_o      = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + StorePtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + StorePtrWidth'(1);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + StoreCntWidth'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - StoreCntWidth'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_data_q[wr_ptr_q] <= wb_data_i;
      fifo_id_q[wr_ptr_q]   <= wb_id_i;
      fifo_last_q[wr_ptr_q] <= wb_last_i;
    end
  end

  // Decode holds new work back until stores drain, so these never overlap
  assign alu_done   = alu_we && wb_last_i;
  assign store_done = pop && fifo_last_q[rd_ptr_q];
  assign done_o     = alu_done || store_done;
  assign done_id_o  = alu_done ? wb_id_i : fifo_id_q[rd_ptr_q];

endmodule

// ==== lane_vrf.sv ====
`timescale 1ns/1ns

module lane_vrf (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  lane_pkg::vaddr_t rd_addr_a_i,
  input  lane_pkg::vaddr_t rd_addr_b_i,
  input  logic             we_i,
  input  lane_pkg::vaddr_t waddr_i,
  input  lane_pkg::elem_t  wdata_i,
  output lane_pkg::elem_t  rd_data_a_o,
  output lane_pkg::elem_t  rd_data_b_o
);
  import lane_pkg::*;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // All registers of the lane with the element index in the low address bits
  elem_t mem_q [NrVRegs*NrElems];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Data shows up the cycle after the address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_a_o <= '0;
      rd_data_b_o <= '0;
    end else begin
      rd_data_a_o <= mem_q[rd_addr_a_i];
      rd_data_b_o <= mem_q[rd_addr_b_i];
    end
  end

endmodule

// ==== tb_vector_lane.sv ====
`timescale 1ns/1ns

module tb_vector_lane;
  import lane_pkg::*;

  localparam logic [31:0] Seed = 32'h7d07_10e4;
  localparam int WaitLimit = 1000;

  logic     clk_i = 1'b0;
  logic     rst_ni, insn_valid_i, ldu_req_i, stu_operand_ready_i;
  lane_op_e insn_op_i;
  vid_t     insn_id_i, done_id_o, next_id;
  vlen_t    insn_vl_i;
  vreg_t    insn_vd_i, insn_vs1_i, insn_vs2_i;
  vaddr_t   ldu_addr_i;
  elem_t    ldu_wdata_i, stu_operand_o, hold_data;
  logic     insn_ready_o, ldu_gnt_o, stu_operand_valid_o, done_o;
  logic     rand_ready, hold_valid;
  logic [31:0] seed, rdy_seed;
  int       cyc;

  // Register file model and expected outputs
  elem_t model [NrVRegs*NrElems];
  elem_t st_data_q [$];
  logic  st_last_q [$];
  vid_t  st_id_q [$];
  int    done_cyc_q [$];
  vid_t  done_id_q [$];

  vector_lane i_vector_lane (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Element result as vs2 op vs1
  function automatic elem_t ref_alu(input lane_op_e op, input elem_t vs2, input elem_t vs1);
    case (op)
      OP_ADD:  return vs2 + vs1;
      OP_SUB:  return vs2 - vs1;
      OP_AND:  return vs2 & vs1;
      OP_OR:   return vs2 | vs1;
      default: return vs2 ^ vs1;
    endcase
  endfunction

  task automatic report_failure();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      report_failure();
    end
  endtask

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic load_elem(input vaddr_t addr, input elem_t data);
    int waited;
    @(posedge clk_i);
    ldu_req_i   <= 1'b1;
    ldu_addr_i  <= addr;
    ldu_wdata_i <= data;
    waited = 0;
    @(negedge clk_i);
    while (!ldu_gnt_o) begin
      waited++;
      if (waited > WaitLimit) begin
        $display("Timeout at %0t ns: load request never granted", $time);
        report_failure();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
    model[addr] = data;
  endtask

  task automatic send_insn(input lane_op_e op, input vlen_t vl, input vreg_t vd,
                           input vreg_t vs1, input vreg_t vs2, output int acc_cyc);
    int waited;
    @(posedge clk_i);
    insn_valid_i <= 1'b1;
    insn_op_i    <= op;
    insn_id_i    <= next_id;
    insn_vl_i    <= vl;
    insn_vd_i    <= vd;
    insn_vs1_i   <= vs1;
    insn_vs2_i   <= vs2;
    waited = 0;
    @(negedge clk_i);
    while (!insn_ready_o) begin
      waited++;
      if (waited > WaitLimit) begin
        $display("Timeout at %0t ns: instruction never accepted", $time);
        report_failure();
      end
      @(negedge clk_i);
    end
    acc_cyc = cyc;
    @(posedge clk_i);
    insn_valid_i <= 1'b0;
  endtask

  task automatic run_alu(input lane_op_e op, input vlen_t vl, input vreg_t vd,
                         input vreg_t vs1, input vreg_t vs2);
    int acc;
    for (int e = 0; e < vl; e++) begin
      model[vd*NrElems+e] = ref_alu(op, model[vs2*NrElems+e], model[vs1*NrElems+e]);
    end
    send_insn(op, vl, vd, vs1, vs2, acc);
    // Last element written vl+2 cycles after acceptance
    done_cyc_q.push_back(acc + vl + 2);
    done_id_q.push_back(next_id);
    next_id++;
  endtask

  task automatic run_store(input vlen_t vl, input vreg_t vs);
    int acc;
    for (int e = 0; e < vl; e++) begin
      st_data_q.push_back(model[vs*NrElems+e]);
      st_last_q.push_back(e == vl - 1);
      st_id_q.push_back(next_id);
    end
    send_insn(OP_STORE, vl, 5'd0, vs, vs, acc);
    next_id++;
  endtask

  ////////////////////////////////////////
  // Store sink and output checker
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    rdy_seed = lcg_next(rdy_seed);
    stu_operand_ready_i <= rand_ready ? rdy_seed[20] : 1'b1;
  end

  always @(negedge clk_i) begin
    cyc <= cyc + 1;
    if (rst_ni) begin
      // No grant without a pending load
      if (!ldu_req_i) begin
        check_eq("load grant without request", ldu_gnt_o, 1'b0);
      end
      // A stalled element must stay put
      if (hold_valid) begin
        check_eq("store valid dropped", stu_operand_valid_o, 1'b1);
        check_eq("stalled store data", stu_operand_o, hold_data);
      end
      if (stu_operand_valid_o && stu_operand_ready_i) begin
        if (st_data_q.size() == 0) begin
          $display("Error at %0t ns: store element with none expected", $time);
          report_failure();
        end
        check_eq("store data", stu_operand_o, st_data_q[0]);
        check_eq("store done pulse", done_o, st_last_q[0]);
        if (st_last_q[0]) begin
          check_eq("store done id", done_id_o, st_id_q[0]);
        end
        st_data_q.delete(0);
        st_last_q.delete(0);
        st_id_q.delete(0);
      end else if (done_o) begin
        if (done_cyc_q.size() == 0) begin
          $display("Error at %0t ns: done pulse with no instruction pending", $time);
          report_failure();
        end
        check_eq("ALU done cycle", cyc, done_cyc_q[0]);
        check_eq("ALU done id", done_id_o, done_id_q[0]);
        done_cyc_q.delete(0);
        done_id_q.delete(0);
      end
      hold_valid = stu_operand_valid_o && !stu_operand_ready_i;
      hold_data  = stu_operand_o;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    vreg_t vd;
    vreg_t prev;
    vreg_t chain [6];
    int    waited;
    rst_ni = 1'b0;
    insn_valid_i = 1'b0;
    insn_op_i = OP_ADD;
    insn_id_i = '0;
    insn_vl_i = '0;
    insn_vd_i = '0;
    insn_vs1_i = '0;
    insn_vs2_i = '0;
    ldu_req_i = 1'b0;
    ldu_addr_i = '0;
    ldu_wdata_i = '0;
    stu_operand_ready_i = 1'b0;
    rand_ready = 1'b0;
    hold_valid = 1'b0;
    hold_data = '0;
    next_id = '0;
    cyc = 0;
    seed = Seed;
    rdy_seed = ~Seed;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_eq("ready after reset", insn_ready_o, 1'b1);
    check_eq("store valid after reset", stu_operand_valid_o, 1'b0);
    check_eq("done after reset", done_o, 1'b0);

    // Fill every element and then read all registers back
    for (int a = 0; a < NrVRegs * NrElems; a++) begin
      seed = lcg_next(seed);
      load_elem(vaddr_t'(a), seed);
    end
    for (int r = 0; r < NrVRegs; r++) begin
      run_store(4'd8, vreg_t'(r));
    end

    // Random ops and lengths under store back-pressure
    rand_ready <= 1'b1;
    for (int k = 0; k < 5; k++) begin
      for (int n = 0; n < 4; n++) begin
        seed = lcg_next(seed);
        vd = seed[31:27];
        run_alu(lane_op_e'(k), vlen_t'(seed[16:14]) + 4'd1, vd, seed[26:22], seed[21:17]);
        run_store(4'd8, vd);
      end
    end

    // Dependent chain where each one reads the previous vd
    seed = lcg_next(seed);
    prev = seed[31:27];
    for (int n = 0; n < 6; n++) begin
      seed = lcg_next(seed);
      chain[n] = seed[31:27];
      run_alu(lane_op_e'(n % 5), 4'd8, chain[n], prev, seed[26:22]);
      prev = chain[n];
    end
    for (int n = 0; n < 6; n++) begin
      run_store(4'd8, chain[n]);
    end

    waited = 0;
    @(negedge clk_i);
    while (st_data_q.size() != 0 || done_cyc_q.size() != 0 || !insn_ready_o) begin
      waited++;
      if (waited > WaitLimit) begin
        $display("Timeout at %0t ns: lane never drained", $time);
        report_failure();
      end
      @(negedge clk_i);
    end
    $display("Test OK");
    $finish;
  end

endmodule

// ==== vector_lane.f ====
lane_pkg.sv
lane_decode.sv
lane_vrf.sv
lane_alu.sv
lane_result.sv
vector_lane.sv
tb_vector_lane.sv

// ==== vector_lane.sv ====
`timescale 1ns/1ns

module vector_lane (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               insn_valid_i,
  input  lane_pkg::lane_op_e insn_op_i,
  input  lane_pkg::vid_t     insn_id_i,
  input  lane_pkg::vlen_t    insn_vl_i,
  input  lane_pkg::vreg_t    insn_vd_i,
  input  lane_pkg::vreg_t    insn_vs1_i,
  input  lane_pkg::vreg_t    insn_vs2_i,
  input  logic               ldu_req_i,
  input  lane_pkg::vaddr_t   ldu_addr_i,
  input  lane_pkg::elem_t    ldu_wdata_i,
  input  logic               stu_operand_ready_i,
  output logic               insn_ready_o,
  output logic               ldu_gnt_o,
  output lane_pkg::elem_t    stu_operand_o,
  output logic               stu_operand_valid_o,
  output logic               done_o,
  output lane_pkg::vid_t     done_id_o
);
  import lane_pkg::*;

  // Element stream into the pipeline
  logic     issue_valid, issue_last;
  lane_op_e issue_op;
  vid_t     issue_id;
  vreg_t    issue_vd;
  eidx_t    issue_eidx;
  vaddr_t   rd_addr_a, rd_addr_b;
  elem_t    rd_data_a, rd_data_b;

  // Writeback and register file write
  logic     wb_valid, wb_last;
  lane_op_e wb_op;
  vid_t     wb_id;
  vaddr_t   wb_addr, vrf_waddr;
  elem_t    wb_data, vrf_wdata;
  logic     vrf_we, store_credit;

  lane_decode i_lane_decode (
    .clk_i         (clk_i       ),
    .rst_ni        (rst_ni      ),
    .insn_valid_i  (insn_valid_i),
    .insn_op_i     (insn_op_i   ),
    .insn_id_i     (insn_id_i   ),
    .insn_vl_i     (insn_vl_i   ),
    .insn_vd_i     (insn_vd_i   ),
    .insn_vs1_i    (insn_vs1_i  ),
    .insn_vs2_i    (insn_vs2_i  ),
    .store_credit_i(store_credit),
    .insn_ready_o  (insn_ready_o),
    .issue_valid_o (issue_valid ),
    .issue_op_o    (issue_op    ),
    .issue_id_o    (issue_id    ),
    .issue_vd_o    (issue_vd    ),
    .issue_eidx_o  (issue_eidx  ),
    .issue_last_o  (issue_last  ),
    .rd_addr_a_o   (rd_addr_a   ),
    .rd_addr_b_o   (rd_addr_b   )
  );

  lane_vrf i_lane_vrf (
    .clk_i      (clk_i    ),
    .rst_ni     (rst_ni   ),
    .rd_addr_a_i(rd_addr_a),
    .rd_addr_b_i(rd_addr_b),
    .we_i       (vrf_we   ),
    .waddr_i    (vrf_waddr),
    .wdata_i    (vrf_wdata),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b)
  );

  lane_alu i_lane_alu (
    .clk_i        (clk_i      ),
    .rst_ni       (rst_ni     ),
    .issue_valid_i(issue_valid),
    .issue_op_i   (issue_op   ),
    .issue_id_i   (issue_id   ),
    .issue_vd_i   (issue_vd   ),
    .issue_eidx_i (issue_eidx ),
    .issue_last_i (issue_last ),
    .rd_data_a_i  (rd_data_a  ),
    .rd_data_b_i  (rd_data_b  ),
    .wb_valid_o   (wb_valid   ),
    .wb_op_o      (wb_op      ),
    .wb_id_o      (wb_id      ),
    .wb_addr_o    (wb_addr    ),
    .wb_data_o    (wb_data    ),
    .wb_last_o    (wb_last    )
  );

  lane_result i_lane_result (
    .clk_i              (clk_i              ),
    .rst_ni             (rst_ni             ),
    .wb_valid_i         (wb_valid           ),
    .wb_op_i            (wb_op              ),
    .wb_id_i            (wb_id              ),
    .wb_addr_i          (wb_addr            ),
    .wb_data_i          (wb_data            ),
    .wb_last_i          (wb_last            ),
    .ldu_req_i          (ldu_req_i          ),
    .ldu_addr_i         (ldu_addr_i         ),
    .ldu_wdata_i        (ldu_wdata_i        ),
    .stu_operand_ready_i(stu_operand_ready_i),
    .ldu_gnt_o          (ldu_gnt_o          ),
    .we_o               (vrf_we             ),
    .waddr_o            (vrf_waddr          ),
    .wdata_o            (vrf_wdata          ),
    .stu_operand_o      (stu_operand_o      ),
    .stu_operand_valid_o(stu_operand_valid_o),
    .store_credit_o     (store_credit       ),
    .done_o             (done_o             ),
    .done_id_o          (done_id_o          )
  );

endmodule
